// ==== src/ex_cfg.svh ====
`ifndef EX_CFG_SVH
`define EX_CFG_SVH

// data and address width
`define XLEN 32

// integer register file size
`define REG_COUNT 32

// bits needed to name one register
`define REG_IDX_W 5

// byte lanes on the data bus
`define SEL_W (`XLEN / 8)

`endif

// ==== src/rv_isa_pkg.sv ====
`default_nettype none

`include "ex_cfg.svh"

package rv_isa_pkg;

  // base opcodes handled by this stage
  typedef enum logic [6:0] {
    OPC_LUI    = 7'b0110111,
    OPC_AUIPC  = 7'b0010111,
    OPC_JAL    = 7'b1101111,
    OPC_JALR   = 7'b1100111,
    OPC_BRANCH = 7'b1100011,
    OPC_LOAD   = 7'b0000011,
    OPC_STORE  = 7'b0100011,
    OPC_OP_IMM = 7'b0010011,
    OPC_OP     = 7'b0110011
  } rv_opcode_e;

  // encoding follows funct3, with SUB and SRA at the top
  typedef enum logic [3:0] {
    ALU_ADD  = 4'd0,
    ALU_SLL  = 4'd1,
    ALU_SLT  = 4'd2,
    ALU_SLTU = 4'd3,
    ALU_XOR  = 4'd4,
    ALU_SRL  = 4'd5,
    ALU_OR   = 4'd6,
    ALU_AND  = 4'd7,
    ALU_SUB  = 4'd8,
    ALU_SRA  = 4'd13
  } alu_op_e;

  // branch funct3 values
  typedef enum logic [2:0] {
    BR_BEQ  = 3'b000,
    BR_BNE  = 3'b001,
    BR_BLT  = 3'b100,
    BR_BGE  = 3'b101,
    BR_BLTU = 3'b110,
    BR_BGEU = 3'b111
  } branch_e;

  // load/store funct3 values, shared by both
  typedef enum logic [2:0] {
    MEM_B  = 3'b000,
    MEM_H  = 3'b001,
    MEM_W  = 3'b010,
    MEM_BU = 3'b100,
    MEM_HU = 3'b101
  } mem_size_e;

  typedef enum logic [1:0] {A_RS1 = 2'd0, A_PC = 2'd1} a_sel_e;
  typedef enum logic [1:0] {B_RS2 = 2'd0, B_IMM = 2'd1} b_sel_e;
  typedef enum logic [1:0] {WB_ALU = 2'd0, WB_MEM = 2'd1, WB_PC4 = 2'd2} wb_sel_e;

  // instruction formats, msb first
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } rv_r_t;

  typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } rv_i_t;

  typedef struct packed {
    logic [6:0] imm_hi;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_lo;
    logic [6:0] opcode;
  } rv_s_t;

  typedef struct packed {
    logic       imm12;
    logic [5:0] imm10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm4_1;
    logic       imm11;
    logic [6:0] opcode;
  } rv_b_t;

  typedef struct packed {
    logic [19:0] imm31_12;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } rv_u_t;

  typedef struct packed {
    logic       imm20;
    logic [9:0] imm10_1;
    logic       imm11;
    logic [7:0] imm19_12;
    logic [4:0] rd;
    logic [6:0] opcode;
  } rv_j_t;

  // one word, six views
  typedef union packed {
    rv_r_t r;
    rv_i_t i;
    rv_s_t s;
    rv_b_t b;
    rv_u_t u;
    rv_j_t j;
  } rv_instr_u;

  // decoded control for one instruction
  typedef struct packed {
    logic [`REG_IDX_W-1:0] rs1;
    logic [`REG_IDX_W-1:0] rs2;
    logic [`REG_IDX_W-1:0] rd;
    alu_op_e               alu_op;
    a_sel_e                a_sel;
    b_sel_e                b_sel;
    wb_sel_e               wb_sel;
    logic                  rf_wen;
    logic                  mem_read;
    logic                  mem_write;
    mem_size_e             mem_size;
    logic                  branch;
    branch_e               br_type;
    logic                  jal;
    logic                  jalr;
    logic                  illegal;
    logic [`XLEN-1:0]      imm;
  } ex_ctrl_t;

endpackage

`default_nettype wire

// ==== src/ex_bus_pkg.sv ====
`default_nettype none

`include "ex_cfg.svh"

package ex_bus_pkg;

  // wishbone classic master outputs
  typedef struct packed {
    logic              cyc;
    logic              stb;
    logic              we;
    logic [`XLEN-1:0]  adr;
    logic [`SEL_W-1:0] sel;
    logic [`XLEN-1:0]  dat_w;
  } wb_req_t;

  // slave side back to the master
  typedef struct packed {
    logic             ack;
    logic [`XLEN-1:0] dat_r;
  } wb_rsp_t;

  // per-instruction trap cause
  typedef enum logic [1:0] {
    TRAP_NONE             = 2'd0,
    TRAP_ILLEGAL          = 2'd1,
    TRAP_MISALIGNED_LOAD  = 2'd2,
    TRAP_MISALIGNED_STORE = 2'd3
  } trap_e;

  // one entry per accepted instruction
  typedef struct packed {
    logic                  valid;
    logic [`XLEN-1:0]      pc;
    logic                  wen;
    logic [`REG_IDX_W-1:0] rd;
    logic [`XLEN-1:0]      wdata;
    trap_e                 trap;
  } retire_t;

  // next-pc change back to fetch
  typedef struct packed {
    logic             taken;
    logic [`XLEN-1:0] target;
  } redirect_t;

endpackage

`default_nettype wire

// ==== src/ex_decode.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "ex_cfg.svh"

module ex_decode import rv_isa_pkg::*; (
  input  rv_instr_u instr,
  output ex_ctrl_t  ctrl
);

  // funct3 to alu op, alt picks SUB/SRA
  function automatic alu_op_e f3_to_alu(input logic [2:0] f3, input logic alt);
    alu_op_e op;
    op = alu_op_e'({1'b0, f3});
    if (alt && f3 == 3'b000)
      op = ALU_SUB;
    else if (alt && f3 == 3'b101)
      op = ALU_SRA;
    return op;
  endfunction

  logic [`XLEN-1:0] imm_i;
  logic [`XLEN-1:0] imm_s;
  logic [`XLEN-1:0] imm_b;
  logic [`XLEN-1:0] imm_u;
  logic [`XLEN-1:0] imm_j;
  logic             f7_zero;
  logic             f7_alt;

  // sign-extended immediates, one per format view
  assign imm_i = {{(`XLEN-12){instr.i.imm[11]}}, instr.i.imm};
  assign imm_s = {{(`XLEN-12){instr.s.imm_hi[6]}}, instr.s.imm_hi, instr.s.imm_lo};
  assign imm_b = {{(`XLEN-12){instr.b.imm12}}, instr.b.imm11, instr.b.imm10_5,
                  instr.b.imm4_1, 1'b0};
  assign imm_u = {instr.u.imm31_12, 12'b0};
  assign imm_j = {{(`XLEN-20){instr.j.imm20}}, instr.j.imm19_12, instr.j.imm11,
                  instr.j.imm10_1, 1'b0};

  // funct7 forms allowed for OP and shifts
  assign f7_zero = (instr.r.funct7 == 7'b0000000);
  assign f7_alt  = (instr.r.funct7 == 7'b0100000);

  always_comb begin
    ctrl          = '0;
    ctrl.rs1      = instr.r.rs1;
    ctrl.rs2      = instr.r.rs2;
    ctrl.rd       = instr.r.rd;
    ctrl.alu_op   = ALU_ADD;
    ctrl.a_sel    = A_RS1;
    ctrl.b_sel    = B_IMM;
    ctrl.wb_sel   = WB_ALU;
    // same funct3 slot for loads, stores and branches
    ctrl.mem_size = mem_size_e'(instr.i.funct3);
    ctrl.br_type  = branch_e'(instr.b.funct3);
    case (instr.r.opcode)
      OPC_LUI: begin
        // rs1 forced to x0 so the alu passes the immediate
        ctrl.rs1    = '0;
        ctrl.imm    = imm_u;
        ctrl.rf_wen = 1'b1;
      end
      OPC_AUIPC: begin
        ctrl.a_sel  = A_PC;
        ctrl.imm    = imm_u;
        ctrl.rf_wen = 1'b1;
      end
      OPC_JAL: begin
        ctrl.imm    = imm_j;
        ctrl.jal    = 1'b1;
        ctrl.wb_sel = WB_PC4;
        ctrl.rf_wen = 1'b1;
      end
      OPC_JALR: begin
        ctrl.imm     = imm_i;
        ctrl.jalr    = 1'b1;
        ctrl.wb_sel  = WB_PC4;
        ctrl.rf_wen  = 1'b1;
        ctrl.illegal = (instr.i.funct3 != 3'b000);
      end
      OPC_BRANCH: begin
        ctrl.imm     = imm_b;
        ctrl.branch  = 1'b1;
        // funct3 010 and 011 are unassigned
        ctrl.illegal = (instr.b.funct3[2:1] == 2'b01);
      end
      OPC_LOAD: begin
        ctrl.imm      = imm_i;
        ctrl.mem_read = 1'b1;
        ctrl.wb_sel   = WB_MEM;
        ctrl.rf_wen   = 1'b1;
        ctrl.illegal  = (instr.i.funct3 == 3'b011) || (instr.i.funct3[2:1] == 2'b11);
      end
      OPC_STORE: begin
        ctrl.imm       = imm_s;
        ctrl.mem_write = 1'b1;
        ctrl.illegal   = (instr.s.funct3[2] || instr.s.funct3 == 3'b011);
      end
      OPC_OP_IMM: begin
        ctrl.imm    = imm_i;
        ctrl.rf_wen = 1'b1;
        ctrl.alu_op = f3_to_alu(instr.i.funct3, instr.i.funct3 == 3'b101 && f7_alt);
        // shift immediates carry funct7 in the upper bits
        if (instr.i.funct3 == 3'b001)
          ctrl.illegal = !f7_zero;
        else if (instr.i.funct3 == 3'b101)
          ctrl.illegal = !(f7_zero || f7_alt);
      end
      OPC_OP: begin
        ctrl.b_sel  = B_RS2;
        ctrl.rf_wen = 1'b1;
        ctrl.alu_op = f3_to_alu(instr.r.funct3, f7_alt);
        // alternate form only on ADD/SUB and SRL/SRA
        if (f7_alt)
          ctrl.illegal = !(instr.r.funct3 == 3'b000 || instr.r.funct3 == 3'b101);
        else
          ctrl.illegal = !f7_zero;
      end
      default: begin
        ctrl.illegal = 1'b1;
      end
    endcase
    // unknown encoding: no state change, no jump
    if (ctrl.illegal) begin
      ctrl.rf_wen    = 1'b0;
      ctrl.mem_read  = 1'b0;
      ctrl.mem_write = 1'b0;
      ctrl.branch    = 1'b0;
      ctrl.jal       = 1'b0;
      ctrl.jalr      = 1'b0;
    end
    // x0 is never reported as written
    if (ctrl.rd == '0)
      ctrl.rf_wen = 1'b0;
  end

endmodule

`default_nettype wire

// ==== src/ex_regfile.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "ex_cfg.svh"

module ex_regfile (
  input  logic                  CLK,
  input  logic                  nRST,
  input  logic [`REG_IDX_W-1:0] rs1,
  input  logic [`REG_IDX_W-1:0] rs2,
  output logic [`XLEN-1:0]      rs1_data,
  output logic [`XLEN-1:0]      rs2_data,
  input  logic                  wen,
  input  logic [`REG_IDX_W-1:0] rd,
  input  logic [`XLEN-1:0]      wdata
);

  logic [`XLEN-1:0] regs [`REG_COUNT];

  // single write port, x0 never written
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      for (int k = 0; k < `REG_COUNT; k++)
        regs[k] <= '0;
    end else if (wen && rd != '0) begin
      regs[rd] <= wdata;
    end
  end

  // async reads, x0 stays at its reset value
  assign rs1_data = regs[rs1];
  assign rs2_data = regs[rs2];

endmodule

`default_nettype wire

// ==== src/ex_execute.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "ex_cfg.svh"

module ex_execute import rv_isa_pkg::*, ex_bus_pkg::*; (
  input  ex_ctrl_t         ctrl,
  input  logic [`XLEN-1:0] pc,
  input  logic [`XLEN-1:0] rs1_data,
  input  logic [`XLEN-1:0] rs2_data,
  output logic [`XLEN-1:0] alu_out,
  output redirect_t        redirect
);

  logic [`XLEN-1:0] op_a;
  logic [`XLEN-1:0] op_b;
  logic [4:0]       shamt;
  logic             eq;
  logic             lt;
  logic             ltu;
  logic             cond;
  logic [`XLEN-1:0] jalr_sum;

  // operand muxes
  assign op_a  = (ctrl.a_sel == A_PC) ? pc : rs1_data;
  assign op_b  = (ctrl.b_sel == B_IMM) ? ctrl.imm : rs2_data;
  assign shamt = op_b[4:0];

  always_comb begin
    case (ctrl.alu_op)
      ALU_ADD:  alu_out = op_a + op_b;
      ALU_SUB:  alu_out = op_a - op_b;
      ALU_SLL:  alu_out = op_a << shamt;
      ALU_SLT:  alu_out = {{(`XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
      ALU_SLTU: alu_out = {{(`XLEN-1){1'b0}}, op_a < op_b};
      ALU_XOR:  alu_out = op_a ^ op_b;
      ALU_SRL:  alu_out = op_a >> shamt;
      ALU_SRA:  alu_out = $unsigned($signed(op_a) >>> shamt);
      ALU_OR:   alu_out = op_a | op_b;
      ALU_AND:  alu_out = op_a & op_b;
      default:  alu_out = op_a + op_b;
    endcase
  end

  // branch compare always on the two registers
  assign eq  = (rs1_data == rs2_data);
  assign lt  = ($signed(rs1_data) < $signed(rs2_data));
  assign ltu = (rs1_data < rs2_data);

  always_comb begin
    case (ctrl.br_type)
      BR_BEQ:  cond = eq;
      BR_BNE:  cond = !eq;
      BR_BLT:  cond = lt;
      BR_BGE:  cond = !lt;
      BR_BLTU: cond = ltu;
      BR_BGEU: cond = !ltu;
      default: cond = 1'b0;
    endcase
  end

  // jalr base is rs1, lsb dropped
  assign jalr_sum = rs1_data + ctrl.imm;

  always_comb begin
    redirect.taken = ctrl.jal || ctrl.jalr || (ctrl.branch && cond);
    if (ctrl.jalr)
      redirect.target = {jalr_sum[`XLEN-1:1], 1'b0};
    else
      redirect.target = pc + ctrl.imm;
  end

endmodule

`default_nettype wire

// ==== src/ex_result.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "ex_cfg.svh"

module ex_result import rv_isa_pkg::*, ex_bus_pkg::*; (
  input  logic                  CLK,
  input  logic                  nRST,
  input  logic                  instr_valid,
  input  ex_ctrl_t              ctrl,
  input  logic [`XLEN-1:0]      pc,
  input  logic [`XLEN-1:0]      alu_out,
  input  logic [`XLEN-1:0]      rs2_data,
  input  wb_rsp_t               wb_rsp,
  output wb_req_t               wb_req,
  output logic                  instr_ready,
  output logic                  rf_wen,
  output logic [`REG_IDX_W-1:0] rf_rd,
  output logic [`XLEN-1:0]      rf_wdata,
  output retire_t               retire
);

  logic [1:0]            lane;
  logic                  is_mem;
  logic                  misaligned;
  logic                  mem_go;
  logic                  bus_gap;
  logic                  accept;
  logic [`SEL_W-1:0]     sel;
  logic [`XLEN-1:0]      lane_data;
  logic [`XLEN-1:0]      load_data;
  logic [`XLEN-1:0]      wdata;
  trap_e                 trap;
  logic                  ret_valid;
  logic                  ret_wen;
  trap_e                 ret_trap;
  logic [`XLEN-1:0]      ret_pc;
  logic [`REG_IDX_W-1:0] ret_rd;
  logic [`XLEN-1:0]      ret_wdata;

  // byte offset within the word
  assign lane   = alu_out[1:0];
  assign is_mem = ctrl.mem_read || ctrl.mem_write;

  // halves need even offset, words need zero
  always_comb begin
    case (ctrl.mem_size)
      MEM_H, MEM_HU: misaligned = lane[0];
      MEM_W:         misaligned = (lane != 2'b00);
      default:       misaligned = 1'b0;
    endcase
  end

  // byte enables
  always_comb begin
    case (ctrl.mem_size)
      MEM_B, MEM_BU: sel = `SEL_W'(1) << lane;
      MEM_H, MEM_HU: sel = lane[1] ? 4'b1100 : 4'b0011;
      default:       sel = 4'b1111;
    endcase
  end

  // legal access only, and never in the cycle right after an ack
  assign mem_go = instr_valid && is_mem && !misaligned && !bus_gap;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST)
      bus_gap <= 1'b0;
    else
      bus_gap <= mem_go && wb_rsp.ack;
  end

  always_comb begin
    wb_req.cyc = mem_go;
    wb_req.stb = mem_go;
    wb_req.we  = ctrl.mem_write;
    wb_req.adr = alu_out;
    wb_req.sel = sel;
    // store data copied to every lane
    case (ctrl.mem_size)
      MEM_B:   wb_req.dat_w = {4{rs2_data[7:0]}};
      MEM_H:   wb_req.dat_w = {2{rs2_data[15:0]}};
      default: wb_req.dat_w = rs2_data;
    endcase
  end

  // memory ops wait for ack, everything else goes at once
  assign instr_ready = (is_mem && !misaligned) ? (mem_go && wb_rsp.ack) : 1'b1;
  assign accept      = instr_valid && instr_ready;

  // move the addressed lane down, then extend
  assign lane_data = wb_rsp.dat_r >> {lane, 3'b000};

  always_comb begin
    case (ctrl.mem_size)
      MEM_B:   load_data = {{(`XLEN-8){lane_data[7]}}, lane_data[7:0]};
      MEM_BU:  load_data = {{(`XLEN-8){1'b0}}, lane_data[7:0]};
      MEM_H:   load_data = {{(`XLEN-16){lane_data[15]}}, lane_data[15:0]};
      MEM_HU:  load_data = {{(`XLEN-16){1'b0}}, lane_data[15:0]};
      default: load_data = lane_data;
    endcase
  end

  // write-back source
  always_comb begin
    case (ctrl.wb_sel)
      WB_MEM:  wdata = load_data;
      WB_PC4:  wdata = pc + `XLEN'(4);
      default: wdata = alu_out;
    endcase
  end

  // illegal wins over misaligned
  always_comb begin
    if (ctrl.illegal)
      trap = TRAP_ILLEGAL;
    else if (misaligned && ctrl.mem_read)
      trap = TRAP_MISALIGNED_LOAD;
    else if (misaligned && ctrl.mem_write)
      trap = TRAP_MISALIGNED_STORE;
    else
      trap = TRAP_NONE;
  end

  // regfile write lands on the accept edge
  assign rf_wen   = accept && ctrl.rf_wen && (trap == TRAP_NONE);
  assign rf_rd    = ctrl.rd;
  assign rf_wdata = wdata;

  // retire control, one cycle after accept
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      ret_valid <= 1'b0;
      ret_wen   <= 1'b0;
      ret_trap  <= TRAP_NONE;
    end else begin
      ret_valid <= accept;
      if (accept) begin
        ret_wen  <= rf_wen;
        ret_trap <= trap;
      end
    end
  end

  // retire payload
  always_ff @(posedge CLK) begin
    if (accept) begin
      ret_pc    <= pc;
      ret_rd    <= ctrl.rd;
      ret_wdata <= wdata;
    end
  end

  always_comb begin
    retire.valid = ret_valid;
    retire.pc    = ret_pc;
    retire.wen   = ret_wen;
    retire.rd    = ret_rd;
    retire.wdata = ret_wdata;
    retire.trap  = ret_trap;
  end

endmodule

`default_nettype wire

// ==== src/ex_stage.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "ex_cfg.svh"

module ex_stage import rv_isa_pkg::*, ex_bus_pkg::*; (
  input  logic             CLK,
  input  logic             nRST,
  input  logic             instr_valid,
  input  rv_instr_u        instr,
  input  logic [`XLEN-1:0] pc,
  output logic             instr_ready,
  output redirect_t        redirect,
  output wb_req_t          wb_req,
  input  wb_rsp_t          wb_rsp,
  output retire_t          retire
);

  ex_ctrl_t              ctrl;
  logic [`XLEN-1:0]      rs1_data;
  logic [`XLEN-1:0]      rs2_data;
  logic [`XLEN-1:0]      alu_out;
  logic                  rf_wen;
  logic [`REG_IDX_W-1:0] rf_rd;
  logic [`XLEN-1:0]      rf_wdata;

  ex_decode u_decode (
    .instr (instr),
    .ctrl  (ctrl)
  );

  ex_regfile u_regfile (
    .CLK      (CLK),
    .nRST     (nRST),
    .rs1      (ctrl.rs1),
    .rs2      (ctrl.rs2),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .wen      (rf_wen),
    .rd       (rf_rd),
    .wdata    (rf_wdata)
  );

  // alu, compare, jump target
  ex_execute u_execute (
    .ctrl     (ctrl),
    .pc       (pc),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .alu_out  (alu_out),
    .redirect (redirect)
  );

  // bus access, write-back, retire
  ex_result u_result (
    .CLK         (CLK),
    .nRST        (nRST),
    .instr_valid (instr_valid),
    .ctrl        (ctrl),
    .pc          (pc),
    .alu_out     (alu_out),
    .rs2_data    (rs2_data),
    .wb_rsp      (wb_rsp),
    .wb_req      (wb_req),
    .instr_ready (instr_ready),
    .rf_wen      (rf_wen),
    .rf_rd       (rf_rd),
    .rf_wdata    (rf_wdata),
    .retire      (retire)
  );

endmodule

`default_nettype wire

// ==== dv/ex_stage_checker.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "ex_cfg.svh"

module ex_stage_checker import ex_bus_pkg::*; (
  input logic    CLK,
  input logic    nRST,
  input wb_req_t wb_req,
  input wb_rsp_t wb_rsp,
  input retire_t retire
);

  // strobe only inside a cycle
  a_stb_in_cyc: assert property (@(posedge CLK) disable iff (!nRST)
    wb_req.stb |-> wb_req.cyc)
    else $error("wishbone stb high while cyc is low");

  // request held until the slave acks
  a_req_stable: assert property (@(posedge CLK) disable iff (!nRST)
    (wb_req.stb && !wb_rsp.ack) |=>
      (wb_req.stb && $stable(wb_req.adr) && $stable(wb_req.sel) &&
       $stable(wb_req.we) && $stable(wb_req.dat_w)))
    else $error("wishbone request changed or dropped before ack");

  // at least one lane per access
  a_sel_nonzero: assert property (@(posedge CLK) disable iff (!nRST)
    wb_req.stb |-> (wb_req.sel != '0))
    else $error("wishbone access with no byte lane selected");

  // x0 never reported as written
  a_no_x0_write: assert property (@(posedge CLK) disable iff (!nRST)
    (retire.valid && retire.wen) |-> (retire.rd != '0))
    else $error("retire reports a write to register zero");

endmodule

bind ex_stage ex_stage_checker u_checker (
  .CLK    (CLK),
  .nRST   (nRST),
  .wb_req (wb_req),
  .wb_rsp (wb_rsp),
  .retire (retire)
);

`default_nettype wire

// ==== dv/tb_ex_stage.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "ex_cfg.svh"

module tb_ex_stage import rv_isa_pkg::*, ex_bus_pkg::*;;

  localparam int CLK_HALF  = 50;
  localparam int DRIVE_DLY = 2;
  localparam int MEM_WORDS = 64;
  // all stores and loads hit word 0x40
  localparam int MEM_IDX   = 16;

  // opcodes as listed in the RV32I base spec
  localparam logic [6:0] OP_LUI   = 7'b0110111;
  localparam logic [6:0] OP_AUIPC = 7'b0010111;
  localparam logic [6:0] OP_JAL   = 7'b1101111;
  localparam logic [6:0] OP_JALR  = 7'b1100111;
  localparam logic [6:0] OP_BR    = 7'b1100011;
  localparam logic [6:0] OP_LD    = 7'b0000011;
  localparam logic [6:0] OP_ST    = 7'b0100011;
  localparam logic [6:0] OP_IMM   = 7'b0010011;
  localparam logic [6:0] OP_REG   = 7'b0110011;

  typedef struct packed {
    logic [31:0]      instr;
    logic [`XLEN-1:0] pc;
    logic             wen;
    logic [4:0]       rd;
    logic [`XLEN-1:0] wdata;
    trap_e            trap;
    logic             taken;
    logic [`XLEN-1:0] target;
    logic             chk_tgt;
    logic             chk_mem;
    logic [`XLEN-1:0] mem_word;
    logic             no_bus;
  } row_t;

  logic             CLK;
  logic             nRST;
  logic             instr_valid;
  rv_instr_u        instr;
  logic [`XLEN-1:0] pc;
  logic             instr_ready;
  redirect_t        redirect;
  wb_req_t          wb_req;
  wb_rsp_t          wb_rsp = '0;
  retire_t          retire;

  row_t             rows[$];
  logic             table_ready = 1'b0;
  int               bus_starts = 0;
  logic [`XLEN-1:0] mem [MEM_WORDS];

  ex_stage DUT (
    .CLK         (CLK),
    .nRST        (nRST),
    .instr_valid (instr_valid),
    .instr       (instr),
    .pc          (pc),
    .instr_ready (instr_ready),
    .redirect    (redirect),
    .wb_req      (wb_req),
    .wb_rsp      (wb_rsp),
    .retire      (retire)
  );

  initial begin
    CLK = 1'b0;
    forever #CLK_HALF CLK = ~CLK;
  end

  // instruction encoders in ISA field order
  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3,
                                        input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, OP_REG};
  endfunction

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd,
                                        input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], OP_ST};
  endfunction

  function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OP_BR};
  endfunction

  function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd,
                                        input logic [6:0] op);
    return {imm, rd, op};
  endfunction

  function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OP_JAL};
  endfunction

  task automatic add_row(input logic [31:0] ins, input logic [31:0] p, input logic wen,
                         input logic [4:0] rd, input logic [31:0] wd, input trap_e tr,
                         input logic tk, input logic [31:0] tgt, input logic ct,
                         input logic cm, input logic [31:0] mw, input logic nb);
    row_t r;
    r = '{ins, p, wen, rd, wd, tr, tk, tgt, ct, cm, mw, nb};
    rows.push_back(r);
  endtask

  // plain register write with pc from the row index
  task automatic alu_row(input logic [31:0] ins, input logic [4:0] rd,
                         input logic [31:0] wd);
    add_row(ins, 32'h1000 + 32'(rows.size() * 4), 1'b1, rd, wd, TRAP_NONE,
            1'b0, '0, 1'b0, 1'b0, '0, 1'b0);
  endtask

  task automatic br_row(input logic [31:0] ins, input logic [31:0] p, input logic tk,
                        input logic [31:0] tgt);
    add_row(ins, p, 1'b0, '0, '0, TRAP_NONE, tk, tgt, 1'b1, 1'b0, '0, 1'b0);
  endtask

  task automatic st_row(input logic [31:0] ins, input logic [31:0] mw);
    add_row(ins, 32'h1000 + 32'(rows.size() * 4), 1'b0, '0, '0, TRAP_NONE,
            1'b0, '0, 1'b0, 1'b1, mw, 1'b0);
  endtask

  task automatic build_table();
    // alu and immediates leave x2 = -5 and x3 = 7
    alu_row(enc_u(20'h12345, 5'd1, OP_LUI), 5'd1, 32'h1234_5000);
    alu_row(enc_i(12'hFFB, 5'd0, 3'd0, 5'd2, OP_IMM), 5'd2, 32'hFFFF_FFFB);
    alu_row(enc_i(12'h007, 5'd0, 3'd0, 5'd3, OP_IMM), 5'd3, 32'h0000_0007);
    alu_row(enc_i(12'h678, 5'd1, 3'd0, 5'd1, OP_IMM), 5'd1, 32'h1234_5678);
    alu_row(enc_r(7'h20, 5'd2, 5'd3, 3'd0, 5'd4), 5'd4, 32'h0000_000C);
    alu_row(enc_r(7'h20, 5'd3, 5'd2, 3'd5, 5'd5), 5'd5, 32'hFFFF_FFFF);
    alu_row(enc_r(7'h00, 5'd3, 5'd2, 3'd5, 5'd6), 5'd6, 32'h01FF_FFFF);
    alu_row(enc_r(7'h00, 5'd2, 5'd3, 3'd3, 5'd7), 5'd7, 32'h0000_0001);
    alu_row(enc_r(7'h00, 5'd3, 5'd2, 3'd2, 5'd8), 5'd8, 32'h0000_0001);
    alu_row(enc_i(12'hFFF, 5'd1, 3'd4, 5'd9, OP_IMM), 5'd9, 32'hEDCB_A987);
    alu_row(enc_i(12'h401, 5'd2, 3'd5, 5'd10, OP_IMM), 5'd10, 32'hFFFF_FFFD);
    alu_row(enc_i(12'h004, 5'd3, 3'd1, 5'd11, OP_IMM), 5'd11, 32'h0000_0070);
    alu_row(enc_r(7'h00, 5'd11, 5'd3, 3'd6, 5'd12), 5'd12, 32'h0000_0077);
    add_row(enc_u(20'h00001, 5'd13, OP_AUIPC), 32'h200, 1'b1, 5'd13, 32'h0000_1200,
            TRAP_NONE, 1'b0, '0, 1'b0, 1'b0, '0, 1'b0);
    // every branch type both ways
    br_row(enc_b(13'h0010, 5'd3, 5'd3, 3'd0), 32'h300, 1'b1, 32'h310);
    br_row(enc_b(13'h0010, 5'd3, 5'd2, 3'd0), 32'h304, 1'b0, 32'h314);
    br_row(enc_b(13'h1FF8, 5'd3, 5'd2, 3'd1), 32'h308, 1'b1, 32'h300);
    br_row(enc_b(13'h0008, 5'd3, 5'd3, 3'd1), 32'h30C, 1'b0, 32'h314);
    br_row(enc_b(13'h0020, 5'd3, 5'd2, 3'd4), 32'h310, 1'b1, 32'h330);
    br_row(enc_b(13'h0020, 5'd2, 5'd3, 3'd4), 32'h314, 1'b0, 32'h334);
    br_row(enc_b(13'h0040, 5'd2, 5'd3, 3'd5), 32'h318, 1'b1, 32'h358);
    br_row(enc_b(13'h0040, 5'd3, 5'd2, 3'd5), 32'h31C, 1'b0, 32'h35C);
    br_row(enc_b(13'h0004, 5'd2, 5'd3, 3'd6), 32'h320, 1'b1, 32'h324);
    br_row(enc_b(13'h0004, 5'd3, 5'd2, 3'd6), 32'h324, 1'b0, 32'h328);
    br_row(enc_b(13'h1FF0, 5'd3, 5'd2, 3'd7), 32'h328, 1'b1, 32'h318);
    br_row(enc_b(13'h1FF0, 5'd2, 5'd3, 3'd7), 32'h32C, 1'b0, 32'h31C);
    // jalr target 7 + 0x100 has bit 0 set
    add_row(enc_j(21'h00040, 5'd14), 32'h400, 1'b1, 5'd14, 32'h404, TRAP_NONE,
            1'b1, 32'h440, 1'b1, 1'b0, '0, 1'b0);
    add_row(enc_i(12'h100, 5'd3, 3'd0, 5'd15, OP_JALR), 32'h440, 1'b1, 5'd15, 32'h444,
            TRAP_NONE, 1'b1, 32'h106, 1'b1, 1'b0, '0, 1'b0);
    // x16 holds the base 0x40 and x17 the store pattern
    alu_row(enc_i(12'h040, 5'd0, 3'd0, 5'd16, OP_IMM), 5'd16, 32'h0000_0040);
    alu_row(enc_u(20'hA1B2C, 5'd17, OP_LUI), 5'd17, 32'hA1B2_C000);
    alu_row(enc_i(12'h3D4, 5'd17, 3'd0, 5'd17, OP_IMM), 5'd17, 32'hA1B2_C3D4);
    st_row(enc_s(12'h000, 5'd17, 5'd16, 3'd2), 32'hA1B2_C3D4);
    st_row(enc_s(12'h001, 5'd3, 5'd16, 3'd0), 32'hA1B2_07D4);
    st_row(enc_s(12'h003, 5'd2, 5'd16, 3'd0), 32'hFBB2_07D4);
    st_row(enc_s(12'h002, 5'd2, 5'd16, 3'd1), 32'hFFFB_07D4);
    st_row(enc_s(12'h000, 5'd3, 5'd16, 3'd1), 32'hFFFB_0007);
    st_row(enc_s(12'h000, 5'd11, 5'd16, 3'd0), 32'hFFFB_0070);
    st_row(enc_s(12'h002, 5'd17, 5'd16, 3'd0), 32'hFFD4_0070);
    // loads from 0xFFD40070
    alu_row(enc_i(12'h000, 5'd16, 3'd2, 5'd18, OP_LD), 5'd18, 32'hFFD4_0070);
    alu_row(enc_i(12'h002, 5'd16, 3'd0, 5'd19, OP_LD), 5'd19, 32'hFFFF_FFD4);
    alu_row(enc_i(12'h002, 5'd16, 3'd4, 5'd20, OP_LD), 5'd20, 32'h0000_00D4);
    alu_row(enc_i(12'h002, 5'd16, 3'd1, 5'd21, OP_LD), 5'd21, 32'hFFFF_FFD4);
    alu_row(enc_i(12'h002, 5'd16, 3'd5, 5'd22, OP_LD), 5'd22, 32'h0000_FFD4);
    alu_row(enc_i(12'h000, 5'd16, 3'd0, 5'd23, OP_LD), 5'd23, 32'h0000_0070);
    alu_row(enc_i(12'h000, 5'd16, 3'd1, 5'd24, OP_LD), 5'd24, 32'h0000_0070);
    // misaligned load then read x18 back
    add_row(enc_i(12'h001, 5'd16, 3'd1, 5'd18, OP_LD), 32'h500, 1'b0, '0, '0,
            TRAP_MISALIGNED_LOAD, 1'b0, '0, 1'b0, 1'b0, '0, 1'b1);
    alu_row(enc_r(7'h00, 5'd0, 5'd18, 3'd0, 5'd25), 5'd25, 32'hFFD4_0070);
    add_row(enc_s(12'h002, 5'd17, 5'd16, 3'd2), 32'h504, 1'b0, '0, '0,
            TRAP_MISALIGNED_STORE, 1'b0, '0, 1'b0, 1'b1, 32'hFFD4_0070, 1'b1);
    // opcode 7F is unknown and its rd field names x31
    add_row(32'hFFFF_FFFF, 32'h508, 1'b0, '0, '0, TRAP_ILLEGAL,
            1'b0, '0, 1'b0, 1'b0, '0, 1'b1);
    add_row(enc_i(12'h005, 5'd0, 3'd0, 5'd0, OP_IMM), 32'h50C, 1'b0, '0, '0,
            TRAP_NONE, 1'b0, '0, 1'b0, 1'b0, '0, 1'b0);
    alu_row(enc_r(7'h00, 5'd31, 5'd0, 3'd0, 5'd26), 5'd26, 32'h0000_0000);
  endtask

  task automatic stop_on_error(input string what);
    $display("%s", what);
    $display(">>> FAIL");
    $fatal(1, "stopped at first error");
  endtask

  task automatic value_error(input string sig, input logic [31:0] got,
                             input logic [31:0] exp);
    stop_on_error($sformatf("** Error at %0t ns: %s got %h expected %h",
                            $time, sig, got, exp));
  endtask

  task automatic check_retire(input retire_t got, input retire_t exp);
    if (got.valid !== 1'b1)
      stop_on_error("retire.valid was not raised in the cycle after accept");
    if (got.pc !== exp.pc)
      value_error("retire.pc", got.pc, exp.pc);
    if (got.wen !== exp.wen)
      value_error("retire.wen", 32'(got.wen), 32'(exp.wen));
    if (got.trap !== exp.trap)
      value_error("retire.trap", 32'(got.trap), 32'(exp.trap));
    // rd and data only mean something on a write
    if (exp.wen && got.rd !== exp.rd)
      value_error("retire.rd", 32'(got.rd), 32'(exp.rd));
    if (exp.wen && got.wdata !== exp.wdata)
      value_error("retire.wdata", got.wdata, exp.wdata);
  endtask

  task automatic check_redirect(input redirect_t got, input redirect_t exp,
                                input logic chk_tgt);
    if (got.taken !== exp.taken)
      value_error("redirect.taken", 32'(got.taken), 32'(exp.taken));
    if (chk_tgt && got.target !== exp.target)
      value_error("redirect.target", got.target, exp.target);
  endtask

  task automatic check_mem(input logic [`XLEN-1:0] got, input logic [`XLEN-1:0] exp);
    if (got !== exp)
      value_error("mem[0x40]", got, exp);
  endtask

  // memory fill tied to every address bit
  initial begin
    for (int i = 0; i < MEM_WORDS; i++)
      mem[i] = 32'hC3A5_0000 | 32'(i * 4);
  end

  // request sampled mid-cycle away from the edges
  wb_req_t req_q = '0;
  always @(negedge CLK)
    req_q = wb_req;

  // wishbone slave with 0 to 3 wait cycles per access
  logic busy  = 1'b0;
  int   delay = 0;
  always @(posedge CLK) begin
    #1;
    if (!nRST) begin
      wb_rsp = '0;
      busy   = 1'b0;
    end else if (wb_rsp.ack) begin
      // ack lasts one cycle
      wb_rsp.ack = 1'b0;
    end else if (req_q.cyc && req_q.stb) begin
      if (!busy) begin
        busy  = 1'b1;
        delay = int'($urandom % 4);
        bus_starts++;
      end
      if (delay == 0) begin
        if (req_q.we) begin
          for (int l = 0; l < 4; l++)
            if (req_q.sel[l])
              mem[req_q.adr[7:2]][8*l +: 8] = req_q.dat_w[8*l +: 8];
        end
        wb_rsp.dat_r = mem[req_q.adr[7:2]];
        wb_rsp.ack   = 1'b1;
        busy         = 1'b0;
      end else begin
        delay--;
      end
    end
  end

  // one instruction from drive to retire
  task automatic run_row(input int idx);
    row_t      r;
    int        starts_before;
    redirect_t exp_rd;
    retire_t   exp_rt;
    r             = rows[idx];
    starts_before = bus_starts;
    instr_valid   = 1'b1;
    instr         = r.instr;
    pc            = r.pc;
    @(negedge CLK);
    exp_rd.taken  = r.taken;
    exp_rd.target = r.target;
    check_redirect(redirect, exp_rd, r.chk_tgt);
    // ready seen mid-cycle means accept on the next edge
    while (!instr_ready)
      @(negedge CLK);
    @(posedge CLK);
    #DRIVE_DLY;
    instr_valid = 1'b0;
    @(negedge CLK);
    exp_rt.valid = 1'b1;
    exp_rt.pc    = r.pc;
    exp_rt.wen   = r.wen;
    exp_rt.rd    = r.rd;
    exp_rt.wdata = r.wdata;
    exp_rt.trap  = r.trap;
    check_retire(retire, exp_rt);
    if (r.no_bus && bus_starts != starts_before)
      stop_on_error($sformatf("row %0d started a bus cycle it should not have", idx));
    if (r.chk_mem)
      check_mem(mem[MEM_IDX], r.mem_word);
  endtask

  // run limit scales with the table
  initial begin
    wait (table_ready);
    repeat (rows.size() * 8 + 10) @(posedge CLK);
    $display("timeout: the DUT stopped accepting or retiring instructions");
    $display(">>> FAIL");
    $fatal(1, "watchdog expired");
  end

  initial begin
    void'($urandom(86));
    nRST        = 1'b0;
    instr_valid = 1'b0;
    instr       = '0;
    pc          = '0;
    build_table();
    table_ready = 1'b1;
    repeat (3) @(posedge CLK);
    #DRIVE_DLY;
    nRST = 1'b1;
    for (int i = 0; i < rows.size(); i++) begin
      @(posedge CLK);
      #DRIVE_DLY;
      run_row(i);
    end
    $display(">>> PASS");
    $finish;
  end

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+src
src/rv_isa_pkg.sv
src/ex_bus_pkg.sv
src/ex_decode.sv
src/ex_regfile.sv
src/ex_execute.sv
src/ex_result.sv
src/ex_stage.sv
dv/ex_stage_checker.sv
dv/tb_ex_stage.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the ex_stage testbench with Verilator
cd "$(dirname "$0")" || exit 1

rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_ex_stage -f list.f -o tb_sim > build.log 2>&1 \
  || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/tb_sim > sim.log 2>&1 || echo "simulator returned a failing status"
cat sim.log

grep -q "^>>> PASS$" sim.log \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
